//--- source/transducer_defs.svh
`ifndef TRANSDUCER_DEFS_SVH
`define TRANSDUCER_DEFS_SVH

// physical address as seen by the L1.5
`define PHY_ADDR_WIDTH 40

// one L1.5 data word
`define WORD_BITS 64

// instruction cache geometry
`define IC_OFFSET_BITS 5
`define IC_INDEX_BITS 7
`define IC_TAG_BITS 28
`define IC_LINE_BITS 256

// data cache geometry
`define DC_OFFSET_BITS 4
`define DC_INDEX_BITS 8
`define DC_TAG_BITS 28
`define DC_LINE_BITS 128

// block-aligned addresses from the core
`define IC_BLOCK_ADDR_BITS (`PHY_ADDR_WIDTH - `IC_OFFSET_BITS)
`define DC_BLOCK_ADDR_BITS (`PHY_ADDR_WIDTH - `DC_OFFSET_BITS)

`endif

//--- source/l15_msg_pkg.sv
`default_nettype none

`include "transducer_defs.svh"

package l15_msg_pkg;

    // request types driven to the L1.5
    typedef enum logic [4:0] {
        LOAD_RQ  = 5'b00000,
        STORE_RQ = 5'b00001,
        IMISS_RQ = 5'b10000
    } rqtype_e;

    // access size codes
    typedef enum logic [2:0] {
        SZ_1B  = 3'b000,
        SZ_2B  = 3'b001,
        SZ_4B  = 3'b010,
        SZ_8B  = 3'b011,
        SZ_16B = 3'b111
    } size_e;

    // return types coming back from the L1.5
    typedef enum logic [3:0] {
        LOAD_RET  = 4'b0000,
        IFILL_RET = 4'b0001,
        ST_ACK    = 4'b0100,
        INT_RET   = 4'b0111
    } rettype_e;

endpackage

`default_nettype wire

//--- source/core_mem_pkg.sv
`default_nettype none

`include "transducer_defs.svh"

package core_mem_pkg;

    typedef logic [`PHY_ADDR_WIDTH-1:0] phys_addr_t;

    typedef logic [`IC_LINE_BITS-1:0] ic_line_t;
    typedef logic [`DC_LINE_BITS-1:0] dc_line_t;

    typedef logic [`IC_TAG_BITS-1:0] ic_tag_t;
    typedef logic [`DC_TAG_BITS-1:0] dc_tag_t;

    typedef logic [`IC_INDEX_BITS-1:0] ic_index_t;
    typedef logic [`DC_INDEX_BITS-1:0] dc_index_t;

    // instruction miss and load carry only an address
    typedef struct packed {
        phys_addr_t addr;
    } addr_payload_t;

    // data is already in L1.5 byte order
    typedef struct packed {
        phys_addr_t              addr;
        logic [`WORD_BITS-1:0]   data;
        l15_msg_pkg::size_e      size;
    } store_payload_t;

    // core is little endian, L1.5 words are big endian
    function automatic logic [`WORD_BITS-1:0] byte_reverse64(input logic [`WORD_BITS-1:0] word);
        logic [`WORD_BITS-1:0] rev;
        for (int i = 0; i < `WORD_BITS / 8; i++) begin
            rev[8*i +: 8] = word[`WORD_BITS-8-8*i +: 8];
        end
        return rev;
    endfunction

endpackage

`default_nettype wire

//--- source/req_slot.sv
`timescale 1ns/1ps
`default_nettype none

`include "transducer_defs.svh"

module req_slot #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     arrive_i,
    input  payload_t payload_i,
    input  logic     grant_i,
    input  logic     ack_i,
    output logic     pending_o,
    output logic     issued_o,
    output payload_t payload_o
);

    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_ARRIVE,
        SLOT_ISSUE
    } slot_state_e;

    slot_state_e state_q;
    slot_state_e state_d;
    payload_t    payload_q;

    // a new pulse always wins, even over an issued request
    always_comb begin
        state_d = state_q;
        if (ack_i && (state_q == SLOT_ISSUE)) begin
            state_d = SLOT_IDLE;
        end
        if (arrive_i) begin
            state_d = SLOT_ARRIVE;
        end
        if (grant_i && (state_d == SLOT_ARRIVE)) begin
            state_d = SLOT_ISSUE;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= SLOT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (arrive_i) begin
            payload_q <= payload_i;
        end
    end

    assign pending_o = arrive_i || (state_q == SLOT_ARRIVE);
    assign issued_o  = (state_q == SLOT_ISSUE);

    // bypass so a fresh request can be granted right away
    assign payload_o = arrive_i ? payload_i : payload_q;

endmodule

`default_nettype wire

//--- source/l15_req_issuer.sv
`timescale 1ns/1ps
`default_nettype none

`include "transducer_defs.svh"

module l15_req_issuer (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            imiss_valid_i,
    input  logic [`IC_BLOCK_ADDR_BITS-1:0]  imiss_addr_i,
    input  logic                            ld_valid_i,
    input  logic [`DC_BLOCK_ADDR_BITS-1:0]  ld_addr_i,
    input  logic                            st_valid_i,
    input  core_mem_pkg::phys_addr_t        st_addr_i,
    input  logic [`WORD_BITS-1:0]           st_data_i,
    input  l15_msg_pkg::size_e              st_size_i,
    input  logic                            l15_ack_i,
    output logic                            l15_val_o,
    output l15_msg_pkg::rqtype_e            l15_rqtype_o,
    output l15_msg_pkg::size_e              l15_size_o,
    output core_mem_pkg::phys_addr_t        l15_addr_o,
    output logic [`WORD_BITS-1:0]           l15_data_o,
    output logic                            l15_nc_o
);

    import l15_msg_pkg::*;
    import core_mem_pkg::*;

    addr_payload_t  imiss_in;
    addr_payload_t  imiss_buf;
    addr_payload_t  ld_in;
    addr_payload_t  ld_buf;
    store_payload_t st_in;
    store_payload_t st_buf;

    logic imiss_pending;
    logic imiss_issued;
    logic imiss_grant;
    logic imiss_sel;
    logic ld_pending;
    logic ld_issued;
    logic ld_grant;
    logic ld_sel;
    logic st_pending;
    logic st_issued;
    logic st_grant;
    logic st_sel;
    logic any_issued;

    logic                  val_d;
    rqtype_e               rqtype_d;
    size_e                 size_d;
    phys_addr_t            addr_d;
    logic [`WORD_BITS-1:0] data_d;

    // block addresses back to byte addresses
    assign imiss_in.addr = {imiss_addr_i, {`IC_OFFSET_BITS{1'b0}}};
    assign ld_in.addr    = {ld_addr_i, {`DC_OFFSET_BITS{1'b0}}};

    assign st_in.addr = st_addr_i;
    assign st_in.data = byte_reverse64(st_data_i);
    assign st_in.size = st_size_i;

    req_slot #(.payload_t(addr_payload_t)) u_imiss_slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .arrive_i  (imiss_valid_i),
        .payload_i (imiss_in),
        .grant_i   (imiss_grant),
        .ack_i     (l15_ack_i),
        .pending_o (imiss_pending),
        .issued_o  (imiss_issued),
        .payload_o (imiss_buf)
    );

    req_slot #(.payload_t(addr_payload_t)) u_ld_slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .arrive_i  (ld_valid_i),
        .payload_i (ld_in),
        .grant_i   (ld_grant),
        .ack_i     (l15_ack_i),
        .pending_o (ld_pending),
        .issued_o  (ld_issued),
        .payload_o (ld_buf)
    );

    req_slot #(.payload_t(store_payload_t)) u_st_slot (
        .clk       (clk),
        .rst_n     (rst_n),
        .arrive_i  (st_valid_i),
        .payload_i (st_in),
        .grant_i   (st_grant),
        .ack_i     (l15_ack_i),
        .pending_o (st_pending),
        .issued_o  (st_issued),
        .payload_o (st_buf)
    );

    // one outstanding request, imiss over load over store
    assign any_issued  = imiss_issued | ld_issued | st_issued;
    assign imiss_grant = ~any_issued & imiss_pending;
    assign ld_grant    = ~any_issued & ~imiss_pending & ld_pending;
    assign st_grant    = ~any_issued & ~imiss_pending & ~ld_pending & st_pending;

    // slot that will be in issue after this edge
    assign imiss_sel = imiss_grant | (imiss_issued & ~l15_ack_i & ~imiss_valid_i);
    assign ld_sel    = ld_grant | (ld_issued & ~l15_ack_i & ~ld_valid_i);
    assign st_sel    = st_grant | (st_issued & ~l15_ack_i & ~st_valid_i);

    always_comb begin
        val_d    = 1'b0;
        rqtype_d = rqtype_e'(0);
        size_d   = size_e'(0);
        addr_d   = '0;
        data_d   = '0;
        if (imiss_sel) begin
            val_d    = 1'b1;
            rqtype_d = IMISS_RQ;
            size_d   = SZ_4B;
            addr_d   = imiss_buf.addr;
        end else if (ld_sel) begin
            val_d    = 1'b1;
            rqtype_d = LOAD_RQ;
            size_d   = SZ_16B;
            addr_d   = ld_buf.addr;
        end else if (st_sel) begin
            val_d    = 1'b1;
            rqtype_d = STORE_RQ;
            size_d   = st_buf.size;
            addr_d   = st_buf.addr;
            data_d   = st_buf.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            l15_val_o <= 1'b0;
        end else begin
            l15_val_o <= val_d;
        end
    end

    always_ff @(posedge clk) begin
        l15_rqtype_o <= rqtype_d;
        l15_size_o   <= size_d;
        l15_addr_o   <= addr_d;
        l15_data_o   <= data_d;
    end

    // top address bit marks the non-cacheable space
    assign l15_nc_o = l15_addr_o[`PHY_ADDR_WIDTH-1];

endmodule

`default_nettype wire

//--- source/l15_resp_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "transducer_defs.svh"

module l15_resp_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        l15_val_i,
    input  logic [3:0]                  l15_rettype_i,
    input  core_mem_pkg::phys_addr_t    l15_addr_i,
    input  logic [`WORD_BITS-1:0]       l15_data0_i,
    input  logic [`WORD_BITS-1:0]       l15_data1_i,
    input  logic [`WORD_BITS-1:0]       l15_data2_i,
    input  logic [`WORD_BITS-1:0]       l15_data3_i,
    input  logic                        st_valid_i,
    output logic                        resp_ack_o,
    output logic                        ic_fill_valid_o,
    output core_mem_pkg::ic_tag_t       ic_tag_o,
    output core_mem_pkg::ic_index_t     ic_index_o,
    output core_mem_pkg::ic_line_t      ic_line_o,
    output logic                        dc_ld_valid_o,
    output core_mem_pkg::dc_tag_t       dc_tag_o,
    output core_mem_pkg::dc_index_t     dc_index_o,
    output core_mem_pkg::dc_line_t      dc_line_o,
    output logic                        st_complete_o,
    output logic                        st_stall_o,
    output logic                        int_o
);

    import l15_msg_pkg::*;
    import core_mem_pkg::*;

    rettype_e ret_type;
    logic     int_ret;
    logic     st_busy_q;
    logic     int_q;

    assign ret_type   = rettype_e'(l15_rettype_i);
    assign resp_ack_o = l15_val_i;

    // at most one response valid per return
    always_comb begin
        ic_fill_valid_o = 1'b0;
        dc_ld_valid_o   = 1'b0;
        st_complete_o   = 1'b0;
        int_ret         = 1'b0;
        if (l15_val_i) begin
            case (ret_type)
                IFILL_RET: ic_fill_valid_o = 1'b1;
                LOAD_RET:  dc_ld_valid_o   = 1'b1;
                ST_ACK:    st_complete_o   = 1'b1;
                INT_RET:   int_ret         = 1'b1;
                default:   int_ret         = 1'b0;
            endcase
        end
    end

    // word 3 ends up in the top of the fill line
    assign ic_line_o = {byte_reverse64(l15_data3_i), byte_reverse64(l15_data2_i),
                        byte_reverse64(l15_data1_i), byte_reverse64(l15_data0_i)};
    assign dc_line_o = {byte_reverse64(l15_data1_i), byte_reverse64(l15_data0_i)};

    // tag from the high bits, index just below it
    assign ic_tag_o   = l15_addr_i[`PHY_ADDR_WIDTH-1 -: `IC_TAG_BITS];
    assign ic_index_o = l15_addr_i[`PHY_ADDR_WIDTH-1-`IC_TAG_BITS -: `IC_INDEX_BITS];
    assign dc_tag_o   = l15_addr_i[`PHY_ADDR_WIDTH-1 -: `DC_TAG_BITS];
    assign dc_index_o = l15_addr_i[`PHY_ADDR_WIDTH-1-`DC_TAG_BITS -: `DC_INDEX_BITS];

    // store stays busy through the cycle of its ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_busy_q <= 1'b0;
        end else if (st_complete_o) begin
            st_busy_q <= 1'b0;
        end else if (st_valid_i) begin
            st_busy_q <= 1'b1;
        end
    end

    assign st_stall_o = st_busy_q | st_valid_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_q <= 1'b0;
        end else begin
            int_q <= int_ret;
        end
    end

    assign int_o = int_q;

endmodule

`default_nettype wire

//--- source/anycore_l15_transducer.sv
`timescale 1ns/1ps
`default_nettype none

`include "transducer_defs.svh"

module anycore_l15_transducer (
    input  logic                            clk,
    input  logic                            rst_n,
    // core requests
    input  logic                            imiss_valid_i,
    input  logic [`IC_BLOCK_ADDR_BITS-1:0]  imiss_addr_i,
    input  logic                            ld_valid_i,
    input  logic [`DC_BLOCK_ADDR_BITS-1:0]  ld_addr_i,
    input  logic                            st_valid_i,
    input  core_mem_pkg::phys_addr_t        st_addr_i,
    input  logic [`WORD_BITS-1:0]           st_data_i,
    input  l15_msg_pkg::size_e              st_size_i,
    // L1.5 request port
    input  logic                            l15_ack_i,
    output logic                            l15_val_o,
    output l15_msg_pkg::rqtype_e            l15_rqtype_o,
    output l15_msg_pkg::size_e              l15_size_o,
    output core_mem_pkg::phys_addr_t        l15_addr_o,
    output logic [`WORD_BITS-1:0]           l15_data_o,
    output logic                            l15_nc_o,
    // L1.5 return port
    input  logic                            l15_val_i,
    input  logic [3:0]                      l15_rettype_i,
    input  core_mem_pkg::phys_addr_t        l15_addr_i,
    input  logic [`WORD_BITS-1:0]           l15_data0_i,
    input  logic [`WORD_BITS-1:0]           l15_data1_i,
    input  logic [`WORD_BITS-1:0]           l15_data2_i,
    input  logic [`WORD_BITS-1:0]           l15_data3_i,
    output logic                            resp_ack_o,
    // core responses
    output logic                            ic_fill_valid_o,
    output core_mem_pkg::ic_tag_t           ic_tag_o,
    output core_mem_pkg::ic_index_t         ic_index_o,
    output core_mem_pkg::ic_line_t          ic_line_o,
    output logic                            dc_ld_valid_o,
    output core_mem_pkg::dc_tag_t           dc_tag_o,
    output core_mem_pkg::dc_index_t         dc_index_o,
    output core_mem_pkg::dc_line_t          dc_line_o,
    output logic                            st_complete_o,
    output logic                            st_stall_o,
    output logic                            int_o
);

    l15_req_issuer u_issuer (
        .clk           (clk),
        .rst_n         (rst_n),
        .imiss_valid_i (imiss_valid_i),
        .imiss_addr_i  (imiss_addr_i),
        .ld_valid_i    (ld_valid_i),
        .ld_addr_i     (ld_addr_i),
        .st_valid_i    (st_valid_i),
        .st_addr_i     (st_addr_i),
        .st_data_i     (st_data_i),
        .st_size_i     (st_size_i),
        .l15_ack_i     (l15_ack_i),
        .l15_val_o     (l15_val_o),
        .l15_rqtype_o  (l15_rqtype_o),
        .l15_size_o    (l15_size_o),
        .l15_addr_o    (l15_addr_o),
        .l15_data_o    (l15_data_o),
        .l15_nc_o      (l15_nc_o)
    );

    // store valid also starts the store stall
    l15_resp_decoder u_decoder (
        .clk             (clk),
        .rst_n           (rst_n),
        .l15_val_i       (l15_val_i),
        .l15_rettype_i   (l15_rettype_i),
        .l15_addr_i      (l15_addr_i),
        .l15_data0_i     (l15_data0_i),
        .l15_data1_i     (l15_data1_i),
        .l15_data2_i     (l15_data2_i),
        .l15_data3_i     (l15_data3_i),
        .st_valid_i      (st_valid_i),
        .resp_ack_o      (resp_ack_o),
        .ic_fill_valid_o (ic_fill_valid_o),
        .ic_tag_o        (ic_tag_o),
        .ic_index_o      (ic_index_o),
        .ic_line_o       (ic_line_o),
        .dc_ld_valid_o   (dc_ld_valid_o),
        .dc_tag_o        (dc_tag_o),
        .dc_index_o      (dc_index_o),
        .dc_line_o       (dc_line_o),
        .st_complete_o   (st_complete_o),
        .st_stall_o      (st_stall_o),
        .int_o           (int_o)
    );

endmodule

`default_nettype wire

//--- bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// byte 0 of the core word becomes the top byte on the L1.5 side
function automatic logic [63:0] swap_bytes64(input logic [63:0] w);
    logic [63:0] r;
    for (int b = 0; b < 8; b++) begin
        r[63-8*b -: 8] = w[8*b +: 8];
    end
    return r;
endfunction

function automatic rqtype_e exp_rqtype(input int kind);
    case (kind)
        KIND_IMISS: return IMISS_RQ;
        KIND_LD:    return LOAD_RQ;
        default:    return STORE_RQ;
    endcase
endfunction

function automatic size_e exp_size(input int kind, input size_e st_size);
    case (kind)
        KIND_IMISS: return SZ_4B;
        KIND_LD:    return SZ_16B;
        default:    return st_size;
    endcase
endfunction

function automatic logic [39:0] exp_imiss_addr(input logic [34:0] blk);
    return {blk, 5'b00000};
endfunction

function automatic logic [39:0] exp_ld_addr(input logic [35:0] blk);
    return {blk, 4'b0000};
endfunction

function automatic logic [255:0] exp_fill_line(input logic [63:0] d0, input logic [63:0] d1,
                                               input logic [63:0] d2, input logic [63:0] d3);
    return {swap_bytes64(d3), swap_bytes64(d2), swap_bytes64(d1), swap_bytes64(d0)};
endfunction

function automatic logic [127:0] exp_load_line(input logic [63:0] d0, input logic [63:0] d1);
    return {swap_bytes64(d1), swap_bytes64(d0)};
endfunction

// both caches use a 28-bit tag from the top of the address
function automatic logic [27:0] exp_tag(input logic [39:0] a);
    return a[39:12];
endfunction

function automatic logic [6:0] exp_ic_index(input logic [39:0] a);
    return a[11:5];
endfunction

function automatic logic [7:0] exp_dc_index(input logic [39:0] a);
    return a[11:4];
endfunction

`endif

//--- bench/tb_transducer.sv
`timescale 1ns/1ps
`default_nettype none

`include "transducer_defs.svh"

module tb_transducer;

    import l15_msg_pkg::*;
    import core_mem_pkg::*;

    localparam int KIND_IMISS = 0;
    localparam int KIND_LD = 1;
    localparam int KIND_ST = 2;
    // roughly twice the length of all tests with worst-case acknowledge delays
    localparam int TIMEOUT_CYCLES = 4000;

    `include "tb_ref_model.svh"

    logic clk;
    logic rst_n;
    logic imiss_valid_i;
    logic [`IC_BLOCK_ADDR_BITS-1:0] imiss_addr_i;
    logic ld_valid_i;
    logic [`DC_BLOCK_ADDR_BITS-1:0] ld_addr_i;
    logic st_valid_i;
    phys_addr_t st_addr_i;
    logic [63:0] st_data_i;
    size_e st_size_i;
    logic l15_ack_i;
    logic l15_val_o;
    rqtype_e l15_rqtype_o;
    size_e l15_size_o;
    phys_addr_t l15_addr_o;
    logic [63:0] l15_data_o;
    logic l15_nc_o;
    logic l15_val_i;
    logic [3:0] l15_rettype_i;
    phys_addr_t l15_addr_i;
    logic [63:0] l15_data0_i;
    logic [63:0] l15_data1_i;
    logic [63:0] l15_data2_i;
    logic [63:0] l15_data3_i;
    logic resp_ack_o;
    logic ic_fill_valid_o;
    ic_tag_t ic_tag_o;
    ic_index_t ic_index_o;
    ic_line_t ic_line_o;
    logic dc_ld_valid_o;
    dc_tag_t dc_tag_o;
    dc_index_t dc_index_o;
    dc_line_t dc_line_o;
    logic st_complete_o;
    logic st_stall_o;
    logic int_o;

    logic [31:0] lfsr_state = 32'hc6e4;
    logic [63:0] rnd;
    int errors = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int reqs_checked = 0;
    int int_count = 0;
    int cycle_count = 0;
    int int_before;
    int ack_delay;

    // expected L1.5 requests in issue order
    rqtype_e exp_type_q[$];
    size_e exp_size_q[$];
    logic [39:0] exp_addr_q[$];
    logic [63:0] exp_data_q[$];

    logic holding = 1'b0;
    logic acked_last = 1'b0;
    rqtype_e hold_type;
    size_e hold_size;
    logic [39:0] hold_addr;
    logic [63:0] hold_data;
    logic exp_fill;
    logic exp_load;
    logic exp_done;
    logic exp_busy = 1'b0;
    logic int_exp = 1'b0;

    anycore_l15_transducer dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h80200003;
        end
        return n;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic value_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic protocol_problem(input string msg);
        $display("%s (at %0t)", msg, $time);
        errors++;
    endtask

    task automatic push_expect(input int kind, input logic [39:0] addr, input logic [63:0] data,
                               input size_e st_size);
        exp_type_q.push_back(exp_rqtype(kind));
        exp_size_q.push_back(exp_size(kind, st_size));
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // pushed in priority order so the queue matches the issue order
    task automatic pulse_requests(input logic do_imiss, input logic do_ld, input logic do_st);
        @(negedge clk);
        if (do_imiss) begin
            rnd = rand_bits(`IC_BLOCK_ADDR_BITS);
            imiss_addr_i = rnd[`IC_BLOCK_ADDR_BITS-1:0];
            imiss_valid_i = 1'b1;
            push_expect(KIND_IMISS, exp_imiss_addr(imiss_addr_i), 64'h0, SZ_1B);
        end
        if (do_ld) begin
            rnd = rand_bits(`DC_BLOCK_ADDR_BITS);
            ld_addr_i = rnd[`DC_BLOCK_ADDR_BITS-1:0];
            ld_valid_i = 1'b1;
            push_expect(KIND_LD, exp_ld_addr(ld_addr_i), 64'h0, SZ_1B);
        end
        if (do_st) begin
            rnd = rand_bits(40);
            st_addr_i = rnd[39:0];
            st_data_i = rand_bits(64);
            rnd = rand_bits(2);
            st_size_i = size_e'({1'b0, rnd[1:0]});
            st_valid_i = 1'b1;
            push_expect(KIND_ST, st_addr_i, swap_bytes64(st_data_i), st_size_i);
        end
        @(negedge clk);
        imiss_valid_i = 1'b0;
        ld_valid_i = 1'b0;
        st_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_addr_q.size() != 0 || l15_val_o) begin
            @(negedge clk);
        end
    endtask

    task automatic send_return(input logic [3:0] rtype);
        @(negedge clk);
        rnd = rand_bits(40);
        l15_addr_i = rnd[39:0];
        l15_data0_i = rand_bits(64);
        l15_data1_i = rand_bits(64);
        l15_data2_i = rand_bits(64);
        l15_data3_i = rand_bits(64);
        l15_rettype_i = rtype;
        l15_val_i = 1'b1;
        @(negedge clk);
        l15_val_i = 1'b0;
    endtask

    task automatic end_test(input string name);
        int bad;
        bad = errors - errors_at_start;
        if (bad == 0) begin
            $display("%-22s ok", name);
        end else begin
            $display("%-22s %0d errors", name, bad);
            tests_bad++;
        end
        tests_run++;
        errors_at_start = errors;
    endtask

    // L1.5 model acknowledges each request after 0 to 7 cycles
    initial begin
        forever begin
            @(negedge clk);
            if (l15_val_o) begin
                rnd = rand_bits(3);
                ack_delay = int'(rnd[2:0]);
                repeat (ack_delay) @(negedge clk);
                l15_ack_i = 1'b1;
                @(negedge clk);
                l15_ack_i = 1'b0;
            end
        end
    end

    // compare at each rising edge on values settled since the falling edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (acked_last) begin
                assert (!l15_val_o) else value_mismatch("request valid stayed high after ack");
                acked_last = 1'b0;
            end
            if (l15_val_o && !holding) begin
                assert (exp_addr_q.size() != 0)
                else protocol_problem("a request was issued while none was expected");
                if (exp_addr_q.size() != 0) begin
                    assert (l15_rqtype_o == exp_type_q[0] && l15_size_o == exp_size_q[0] &&
                            l15_addr_o == exp_addr_q[0] && l15_data_o == exp_data_q[0] &&
                            l15_nc_o == exp_addr_q[0][39])
                    else value_mismatch($sformatf(
                        "request type %0h size %0h addr %h data %h, expected %0h %0h %h %h",
                        l15_rqtype_o, l15_size_o, l15_addr_o, l15_data_o,
                        exp_type_q[0], exp_size_q[0], exp_addr_q[0], exp_data_q[0]));
                end
                hold_type = l15_rqtype_o;
                hold_size = l15_size_o;
                hold_addr = l15_addr_o;
                hold_data = l15_data_o;
                holding = 1'b1;
            end else if (l15_val_o) begin
                assert (l15_rqtype_o == hold_type && l15_size_o == hold_size &&
                        l15_addr_o == hold_addr && l15_data_o == hold_data)
                else value_mismatch("request fields changed before ack");
            end
            if (l15_val_o && l15_ack_i && exp_addr_q.size() != 0) begin
                void'(exp_type_q.pop_front());
                void'(exp_size_q.pop_front());
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                reqs_checked++;
                holding = 1'b0;
                acked_last = 1'b1;
            end

            exp_fill = l15_val_i && (l15_rettype_i == IFILL_RET);
            exp_load = l15_val_i && (l15_rettype_i == LOAD_RET);
            exp_done = l15_val_i && (l15_rettype_i == ST_ACK);
            assert (resp_ack_o == l15_val_i && ic_fill_valid_o == exp_fill &&
                    dc_ld_valid_o == exp_load && st_complete_o == exp_done)
            else value_mismatch($sformatf("response valids wrong for return type %0h",
                l15_rettype_i));
            if (exp_fill) begin
                assert (ic_line_o == exp_fill_line(l15_data0_i, l15_data1_i, l15_data2_i,
                        l15_data3_i) && ic_tag_o == exp_tag(l15_addr_i) &&
                        ic_index_o == exp_ic_index(l15_addr_i))
                else value_mismatch("fill line, tag or index wrong");
            end
            if (exp_load) begin
                assert (dc_line_o == exp_load_line(l15_data0_i, l15_data1_i) &&
                        dc_tag_o == exp_tag(l15_addr_i) &&
                        dc_index_o == exp_dc_index(l15_addr_i))
                else value_mismatch("load line, tag or index wrong");
            end

            // stall covers the pulse cycle through the ack cycle
            assert (st_stall_o == (exp_busy || st_valid_i))
            else value_mismatch($sformatf("store stall is %b", st_stall_o));
            if (exp_done) begin
                exp_busy = 1'b0;
            end else if (st_valid_i) begin
                exp_busy = 1'b1;
            end

            assert (int_o == int_exp) else value_mismatch($sformatf("interrupt is %b", int_o));
            int_exp = l15_val_i && (l15_rettype_i == INT_RET);
            if (int_o) begin
                int_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        imiss_valid_i = 1'b0;
        imiss_addr_i = '0;
        ld_valid_i = 1'b0;
        ld_addr_i = '0;
        st_valid_i = 1'b0;
        st_addr_i = '0;
        st_data_i = '0;
        st_size_i = SZ_1B;
        l15_ack_i = 1'b0;
        l15_val_i = 1'b0;
        l15_rettype_i = 4'h0;
        l15_addr_i = '0;
        l15_data0_i = '0;
        l15_data1_i = '0;
        l15_data2_i = '0;
        l15_data3_i = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        assert (!l15_val_o && !ic_fill_valid_o && !dc_ld_valid_o && !st_complete_o &&
                !st_stall_o && !int_o)
        else value_mismatch("outputs not low after reset");
        end_test("reset");

        for (int i = 0; i < 4; i++) begin
            pulse_requests(1'b1, 1'b0, 1'b0);
            wait_drain();
            pulse_requests(1'b0, 1'b1, 1'b0);
            wait_drain();
            pulse_requests(1'b0, 1'b0, 1'b1);
            wait_drain();
        end
        end_test("single requests");

        for (int i = 0; i < 6; i++) begin
            pulse_requests(1'b1, 1'b1, 1'b1);
            wait_drain();
        end
        end_test("priority order");

        for (int i = 0; i < 30; i++) begin
            rnd = rand_bits(3);
            pulse_requests(rnd[0], rnd[1], rnd[2] || (rnd[2:0] == 3'b000));
            wait_drain();
        end
        end_test("random ack delays");

        for (int i = 0; i < 4; i++) begin
            send_return(IFILL_RET);
            send_return(LOAD_RET);
        end
        send_return(4'h2);
        send_return(4'hf);
        end_test("fill and load returns");

        pulse_requests(1'b0, 1'b0, 1'b1);
        wait_drain();
        assert (st_stall_o) else value_mismatch("store stall low before store ack");
        send_return(ST_ACK);
        assert (!st_stall_o) else value_mismatch("store stall high after store ack");
        end_test("store stall");

        int_before = int_count;
        send_return(INT_RET);
        repeat (3) @(negedge clk);
        assert (int_count - int_before == 1)
        else value_mismatch($sformatf("%0d interrupt pulses", int_count - int_before));
        end_test("interrupt pulse");

        $display("tests %0d, with errors %0d, requests checked %0d, errors %0d",
                 tests_run, tests_bad, reqs_checked, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
+incdir+bench
source/l15_msg_pkg.sv
source/core_mem_pkg.sv
source/req_slot.sv
source/l15_req_issuer.sv
source/l15_resp_decoder.sv
source/anycore_l15_transducer.sv
bench/tb_transducer.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_transducer
FILELIST = project.f
OBJDIR   = obj_dir
PASS_MSG = test passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the simulation output is searched for the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
